//--- sram_bist.f
common/sram_bist_pkg.sv
source/addr_iter.sv
source/pattern_gen.sv
sram_ctrl/sram_ctrl.sv
sram_tester/sram_tester.sv
source/sram_bist_top.sv
verification/sram_model.sv
verification/sram_bist_tb.sv

//--- verification/sram_bist_tb.sv
`default_nettype none
`timescale 1ns/1ps

module sram_bist_tb;

  import sram_bist_pkg::*;

  localparam int test_addr_bits = 6;
  localparam int n_words = 1 << test_addr_bits;
  localparam int run_cycles = 24 * n_words + 2;
  localparam int pass_count = 6;
  localparam int fault_runs = 4;
  // two clean runs, two runs per fault and one run after recovery
  localparam int watchdog_cycles = 3 * run_cycles * (3 + 2 * fault_runs) + 100;

  logic          clk;
  logic          reset;
  logic          test_done;
  logic          test_pass;
  pattern_kind_t pattern_state;
  fail_rec_t     fail;
  addr_t         io_addr;
  wire data_t    io_data;
  logic          io_we_n;
  logic          io_oe_n;
  logic          io_ce_n;
  logic          fault_en;
  addr_t         fault_addr;
  logic [3:0]    fault_bit;
  logic [31:0]   lcg_state;
  int            cycle;
  int            mismatch_count;
  int            other_count;

  sram_bist_top #(
    .ADDR_BITS(test_addr_bits),
    .DATA_BITS(data_bits_default)
  ) sram_bist_top_i (.*);

  sram_model #(
    .ADDR_BITS(test_addr_bits)
  ) sram_model_i (.*);

  always #4 clk = ~clk;

  always @(posedge clk) begin
    cycle <= cycle + 1;
  end

  function automatic logic [31:0] lcg_next();
    lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
    return lcg_state;
  endfunction

  task automatic check_data(input string name, input data_t expected, input data_t actual);
    if (actual !== expected) begin
      mismatch_count++;
      $display("Mismatch %s: expected %h, actual %h", name, expected, actual);
    end
  endtask

  task automatic check_addr(input string name, input addr_t expected, input addr_t actual);
    if (actual !== expected) begin
      mismatch_count++;
      $display("Mismatch %s: expected %h, actual %h", name, expected, actual);
    end
  endtask

  task automatic check_kind(input string name, input pattern_kind_t expected,
                            input pattern_kind_t actual);
    if (actual !== expected) begin
      mismatch_count++;
      $display("Mismatch %s: expected %s, actual %s", name, expected.name(), actual.name());
    end
  endtask

  task automatic check_flag(input string name, input logic expected, input logic actual);
    if (actual !== expected) begin
      mismatch_count++;
      $display("Mismatch %s: expected %b, actual %b", name, expected, actual);
    end
  endtask

  task automatic check_count(input string name, input int expected, input int actual);
    if (actual != expected) begin
      mismatch_count++;
      $display("Mismatch %s: expected %0d, actual %0d", name, expected, actual);
    end
  endtask

  task automatic report_failure(input string what);
    other_count++;
    $display("%s", what);
  endtask

  // expected word for one pass at one address
  function automatic data_t pattern_word(pattern_kind_t kind, logic [test_addr_bits-1:0] a);
    data_t word;
    int    i;
    word = '0;
    case (kind)
      pat_ones:   word = '1;
      pat_check:  word = 16'h5555;
      pat_icheck: word = 16'haaaa;
      pat_addr, pat_iaddr: begin
        for (i = 0; i < 16; i++) begin
          word[i] = a[i % test_addr_bits];
        end
        if (kind == pat_iaddr) begin
          word = ~word;
        end
      end
      default: word = '0;
    endcase
    return word;
  endfunction

  // earliest pass and lowest address where the stuck bit changes a read
  task automatic find_first_fail(input addr_t fa, input int fb, output pattern_kind_t kind,
                                 output addr_t addr, output data_t word, output bit found);
    int    k;
    int    a;
    data_t w;
    found = 1'b0;
    for (k = 0; k < pass_count && !found; k++) begin
      for (a = 0; a < n_words && !found; a++) begin
        w = pattern_word(pattern_kind_t'(k), a[test_addr_bits-1:0]);
        if (addr_t'(a) == fa && w[fb] == 1'b0) begin
          found = 1'b1;
          kind  = pattern_kind_t'(k);
          addr  = addr_t'(a);
          word  = w;
        end
      end
    end
  endtask

  // waits for test_done (test_pass low when for_fail is set)
  // every word written meanwhile is checked against the pattern
  task automatic wait_status(input int limit, input bit for_fail, input bit check_order,
                             output bit seen);
    int count;
    int pass_no;
    seen    = 1'b0;
    count   = 0;
    pass_no = 0;
    while (!seen && count < limit) begin
      @(negedge clk);
      count++;
      if (io_ce_n === 1'b0 && io_we_n === 1'b0) begin
        check_data("write data", pattern_word(pattern_state, io_addr[test_addr_bits-1:0]),
                   io_data);
      end
      if (check_order && pattern_state !== pattern_kind_t'(pass_no)) begin
        check_kind("pass order", pattern_kind_t'(pass_no + 1), pattern_state);
        pass_no = int'(pattern_state);
      end
      seen = for_fail ? !test_pass : test_done;
    end
  endtask

  task automatic apply_reset(input logic en, input addr_t fa, input logic [3:0] fb);
    @(posedge clk);
    reset      <= 1'b1;
    fault_en   <= en;
    fault_addr <= fa;
    fault_bit  <= fb;
    repeat (3) @(posedge clk);
    reset <= 1'b0;
    @(negedge clk);
  endtask

  initial begin
    bit            seen;
    bit            found;
    int            t_first;
    int            i;
    addr_t         fa;
    logic [3:0]    fb;
    pattern_kind_t fail_kind;
    addr_t         fail_addr;
    data_t         fail_word;

    clk            = 1'b0;
    reset          = 1'b1;
    fault_en       = 1'b0;
    fault_addr     = '0;
    fault_bit      = '0;
    lcg_state      = 32'd91213;
    cycle          = 0;
    mismatch_count = 0;
    other_count    = 0;

    apply_reset(1'b0, '0, '0);
    check_flag("idle test_done", 1'b0, test_done);
    check_flag("idle test_pass", 1'b1, test_pass);
    check_kind("idle pattern_state", pat_zeros, pattern_state);

    // clean run with every pass in order and then one full period
    wait_status(run_cycles + 10, 1'b0, 1'b1, seen);
    if (!seen) begin
      report_failure("no test_done in the first clean run");
    end else begin
      check_kind("last pass", pat_iaddr, pattern_state);
      check_flag("clean test_pass", 1'b1, test_pass);
      t_first = cycle;
      wait_status(run_cycles + 10, 1'b0, 1'b0, seen);
      if (!seen) begin
        report_failure("no second test_done in the clean run");
      end else begin
        check_count("run period", run_cycles, cycle - t_first);
      end
    end

    for (i = 0; i < fault_runs; i++) begin
      fa = addr_t'(lcg_next() >> 26);
      fb = 4'(lcg_next() >> 28);
      apply_reset(1'b1, fa, fb);
      find_first_fail(fa, int'(fb), fail_kind, fail_addr, fail_word, found);
      wait_status(run_cycles + 10, 1'b1, 1'b0, seen);
      if (!found || !seen) begin
        report_failure("injected stuck bit did not clear test_pass");
      end else begin
        check_addr("fail.addr", fail_addr, fail.addr);
        check_data("fail.expected", fail_word, fail.expected);
        check_data("fail.actual", fail_word | (data_t'(1) << fb), fail.actual);
        check_kind("failing pass", fail_kind, pattern_state);
        // halted sequencer never reports a finished run
        wait_status(run_cycles, 1'b0, 1'b0, seen);
        check_flag("test_done after halt", 1'b0, seen);
      end
    end

    // recovery with the fault removed
    apply_reset(1'b0, '0, '0);
    check_flag("test_pass after reset", 1'b1, test_pass);
    wait_status(run_cycles + 10, 1'b0, 1'b0, seen);
    check_flag("test_done after recovery", 1'b1, seen);
    check_flag("test_pass after recovery", 1'b1, test_pass);

    $display("errors: %0d mismatches, %0d other failures", mismatch_count, other_count);
    if (mismatch_count == 0 && other_count == 0) begin
      $display("Test completed successfully");
    end else begin
      $display("Test failed");
    end
    $finish;
  end

  initial begin
    repeat (watchdog_cycles) @(posedge clk);
    $display("watchdog expired after %0d cycles", watchdog_cycles);
    $display("errors: %0d mismatches, %0d other failures", mismatch_count, other_count + 1);
    $display("Test failed");
    $finish;
  end

endmodule

`default_nettype wire

//--- verification/sram_model.sv
`default_nettype none
`timescale 1ns/1ps

module sram_model #(
  parameter int ADDR_BITS = 6
) (
  input  wire sram_bist_pkg::addr_t io_addr,
  inout  wire sram_bist_pkg::data_t io_data,
  input  wire logic                 io_we_n,
  input  wire logic                 io_oe_n,
  input  wire logic                 io_ce_n,

  // stuck-at-1 fault on one bit of one word
  input  wire logic                 fault_en,
  input  wire sram_bist_pkg::addr_t fault_addr,
  input  wire logic [3:0]           fault_bit
);

  import sram_bist_pkg::*;

  data_t mem [0:(1<<ADDR_BITS)-1];
  data_t read_word;

  // write is transparent while selected with we_n low
  always @(io_addr or io_data or io_we_n or io_ce_n) begin
    if (io_ce_n === 1'b0 && io_we_n === 1'b0) begin
      mem[io_addr[ADDR_BITS-1:0]] = io_data;
    end
  end

  // stored word with the faulty bit forced high
  always @(io_addr or io_oe_n or io_ce_n or fault_en or fault_addr or fault_bit) begin
    read_word = mem[io_addr[ADDR_BITS-1:0]];
    if (fault_en && io_addr[ADDR_BITS-1:0] == fault_addr[ADDR_BITS-1:0]) begin
      read_word[fault_bit] = 1'b1;
    end
  end

  assign io_data = (io_ce_n == 1'b0 && io_oe_n == 1'b0) ? read_word : 'z;

endmodule

`default_nettype wire

//--- source/sram_bist_top.sv
`default_nettype none
`timescale 1ns/1ps

module sram_bist_top #(
  parameter int ADDR_BITS = sram_bist_pkg::addr_bits_default,
  parameter int DATA_BITS = sram_bist_pkg::data_bits_default
) (
  input  wire                          clk,
  input  wire                          reset,
  output logic                         test_done,
  output logic                         test_pass,
  output sram_bist_pkg::pattern_kind_t pattern_state,
  output sram_bist_pkg::fail_rec_t     fail,

  // pads of the external SRAM
  output sram_bist_pkg::addr_t         io_addr,
  inout  wire sram_bist_pkg::data_t    io_data,
  output logic                         io_we_n,
  output logic                         io_oe_n,
  output logic                         io_ce_n
);

  sram_tester #(
    .ADDR_BITS(ADDR_BITS),
    .DATA_BITS(DATA_BITS)
  ) sram_tester_i (
    .clk          (clk),
    .reset        (reset),
    .test_done    (test_done),
    .test_pass    (test_pass),
    .pattern_state(pattern_state),
    .fail         (fail),
    .io_addr      (io_addr),
    .io_data      (io_data),
    .io_we_n      (io_we_n),
    .io_oe_n      (io_oe_n),
    .io_ce_n      (io_ce_n)
  );

endmodule

`default_nettype wire

//--- sram_tester/sram_tester.sv
`default_nettype none
`timescale 1ns/1ps

module sram_tester #(
  parameter int ADDR_BITS = sram_bist_pkg::addr_bits_default,
  parameter int DATA_BITS = sram_bist_pkg::data_bits_default
) (
  input  wire                          clk,
  input  wire                          reset,

  // status
  output logic                         test_done,
  output logic                         test_pass,

  // debug
  output sram_bist_pkg::pattern_kind_t pattern_state,
  output sram_bist_pkg::fail_rec_t     fail,

  // SRAM pins
  output sram_bist_pkg::addr_t         io_addr,
  inout  wire sram_bist_pkg::data_t    io_data,
  output logic                         io_we_n,
  output logic                         io_oe_n,
  output logic                         io_ce_n
);

  import sram_bist_pkg::*;

  tester_state_t state;
  tester_state_t state_next;

  // controller side
  logic  req;
  logic  write_enable;
  logic  write_done;
  data_t read_data;
  logic  read_valid;

  // iterator side
  logic  addr_inc;
  addr_t addr_val;
  logic  addr_last;

  // pattern side
  logic          next_pass;
  logic          restart;
  data_t         pat_data;
  pattern_kind_t pat_kind;
  logic          pat_final;

  data_t expected_q;
  logic  mismatch;

  sram_ctrl #(
    .ADDR_BITS(ADDR_BITS),
    .DATA_BITS(DATA_BITS)
  ) sram_ctrl_i (
    .clk         (clk),
    .reset       (reset),
    .req         (req),
    .write_enable(write_enable),
    .addr        (addr_val),
    .write_data  (pat_data),
    .write_done  (write_done),
    .read_data   (read_data),
    .read_valid  (read_valid),
    .io_addr     (io_addr),
    .io_data     (io_data),
    .io_we_n     (io_we_n),
    .io_oe_n     (io_oe_n),
    .io_ce_n     (io_ce_n)
  );

  addr_iter #(
    .ADDR_BITS(ADDR_BITS)
  ) addr_iter_i (
    .clk  (clk),
    .reset(reset),
    .inc  (addr_inc),
    .val  (addr_val),
    .last (addr_last)
  );

  pattern_gen #(
    .ADDR_BITS(ADDR_BITS),
    .DATA_BITS(DATA_BITS)
  ) pattern_gen_i (
    .clk       (clk),
    .reset     (reset),
    .restart   (restart),
    .next_pass (next_pass),
    .addr      (addr_val),
    .data      (pat_data),
    .kind      (pat_kind),
    .final_pass(pat_final)
  );

  // compare only when the controller returns a word
  assign mismatch = read_valid && (read_data != expected_q);

  always_comb begin
    state_next = state;
    case (state)
      st_start:   state_next = st_writing;
      st_writing: state_next = st_write_hold;
      st_write_hold: begin
        if (write_done) begin
          state_next = addr_last ? st_reading : st_writing;
        end
      end
      st_reading: state_next = st_read_hold;
      st_read_hold: begin
        if (mismatch) begin
          state_next = st_halt;
        end else if (read_valid) begin
          if (!addr_last) begin
            state_next = st_reading;
          end else if (pat_final) begin
            state_next = st_done;
          end else begin
            state_next = st_writing;
          end
        end
      end
      st_done: state_next = st_start;
      st_halt: state_next = st_halt;
      default: state_next = st_start;
    endcase
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      state <= st_start;
    end else begin
      state <= state_next;
    end
  end

  // requests go out from the two access states only
  assign req          = (state == st_writing) || (state == st_reading);
  assign write_enable = (state == st_writing);

  // step the address once the access has completed
  assign addr_inc = ((state == st_write_hold) && write_done) ||
                    ((state == st_read_hold) && read_valid && !mismatch);

  assign next_pass = (state == st_read_hold) && read_valid && !mismatch &&
                     addr_last && !pat_final;
  assign restart   = (state == st_done);
  assign test_done = (state == st_done);

  assign pattern_state = pat_kind;

  // expected word travels with the read request
  always_ff @(posedge clk) begin
    if (state == st_reading) begin
      expected_q <= pat_data;
    end
  end

  // sticky pass flag
  always_ff @(posedge clk) begin
    if (reset) begin
      test_pass <= 1'b1;
    end else if ((state == st_read_hold) && mismatch) begin
      test_pass <= 1'b0;
    end
  end

  // first failure only as the FSM halts right after
  always_ff @(posedge clk) begin
    if ((state == st_read_hold) && mismatch) begin
      fail.addr     <= addr_val;
      fail.expected <= expected_q;
      fail.actual   <= read_data;
    end
  end

endmodule

`default_nettype wire

//--- sram_ctrl/sram_ctrl.sv
`default_nettype none
`timescale 1ns/1ps

module sram_ctrl #(
  parameter int ADDR_BITS = sram_bist_pkg::addr_bits_default,
  parameter int DATA_BITS = sram_bist_pkg::data_bits_default
) (
  input  wire                       clk,
  input  wire                       reset,

  // access requests from the sequencer
  input  wire logic                 req,
  input  wire logic                 write_enable,
  input  wire sram_bist_pkg::addr_t addr,
  input  wire sram_bist_pkg::data_t write_data,
  output logic                      write_done,
  output sram_bist_pkg::data_t      read_data,
  output logic                      read_valid,

  // SRAM pins
  output sram_bist_pkg::addr_t      io_addr,
  inout  wire sram_bist_pkg::data_t io_data,
  output logic                      io_we_n,
  output logic                      io_oe_n,
  output logic                      io_ce_n
);

  import sram_bist_pkg::*;

  logic [ADDR_BITS-1:0] addr_q;
  logic [DATA_BITS-1:0] wdata_q;
  logic [DATA_BITS-1:0] rdata_q;
  logic [DATA_BITS-1:0] pin_data;

  // address and write data for the access cycle
  always_ff @(posedge clk) begin
    if (req) begin
      addr_q  <= addr[ADDR_BITS-1:0];
      wdata_q <= write_data[DATA_BITS-1:0];
    end
  end

  // pin controls and strobes for one access cycle per request
  always_ff @(posedge clk) begin
    if (reset) begin
      io_ce_n    <= 1'b1;
      io_we_n    <= 1'b1;
      io_oe_n    <= 1'b1;
      write_done <= 1'b0;
      read_valid <= 1'b0;
    end else begin
      io_ce_n    <= ~req;
      io_we_n    <= ~(req && write_enable);
      io_oe_n    <= ~(req && !write_enable);
      write_done <= req && write_enable;
      read_valid <= req && !write_enable;
    end
  end

  assign io_addr = addr_t'(addr_q);

  // drive the bus only while writing
  assign io_data = io_we_n ? 'z : data_t'(wdata_q);

  assign pin_data = io_data[DATA_BITS-1:0];

  // sample the bus at the end of the read cycle
  always_ff @(posedge clk) begin
    if (read_valid) begin
      rdata_q <= pin_data;
    end
  end

  // live bus value during the read cycle, then the held sample
  // until the next read
  assign read_data = read_valid ? data_t'(pin_data) : data_t'(rdata_q);

endmodule

`default_nettype wire

//--- source/pattern_gen.sv
`default_nettype none
`timescale 1ns/1ps

module pattern_gen #(
  parameter int ADDR_BITS = sram_bist_pkg::addr_bits_default,
  parameter int DATA_BITS = sram_bist_pkg::data_bits_default
) (
  input  wire                          clk,
  input  wire                          reset,
  input  wire logic                    restart,
  input  wire logic                    next_pass,
  input  wire sram_bist_pkg::addr_t    addr,
  output sram_bist_pkg::data_t         data,
  output sram_bist_pkg::pattern_kind_t kind,
  output logic                         final_pass
);

  import sram_bist_pkg::*;

  // copies of the address needed to cover a data word
  localparam int reps = (DATA_BITS + ADDR_BITS - 1) / ADDR_BITS;

  // 0101 checkerboard built wide and trimmed
  localparam logic [2*DATA_BITS-1:0] check_wide = {DATA_BITS{2'b01}};

  pattern_kind_t             kind_q;
  logic [ADDR_BITS-1:0]      addr_low;
  logic [reps*ADDR_BITS-1:0] addr_rep;
  logic [DATA_BITS-1:0]      word;

  // current pass
  always_ff @(posedge clk) begin
    if (reset || restart) begin
      kind_q <= pat_zeros;
    end else if (next_pass) begin
      if (kind_q == pat_iaddr) begin
        kind_q <= pat_zeros;
      end else begin
        kind_q <= pattern_kind_t'(kind_q + 3'd1);
      end
    end
  end

  // address repeated across the word when it is narrower than the data
  assign addr_low = addr[ADDR_BITS-1:0];
  assign addr_rep = {reps{addr_low}};

  always_comb begin
    case (kind_q)
      pat_zeros:  word = '0;
      pat_ones:   word = '1;
      pat_check:  word = check_wide[DATA_BITS-1:0];
      pat_icheck: word = ~check_wide[DATA_BITS-1:0];
      pat_addr:   word = addr_rep[DATA_BITS-1:0];
      pat_iaddr:  word = ~addr_rep[DATA_BITS-1:0];
      default:    word = '0;
    endcase
  end

  assign data       = data_t'(word);
  assign kind       = kind_q;
  assign final_pass = (kind_q == pat_iaddr);

endmodule

`default_nettype wire

//--- source/addr_iter.sv
`default_nettype none
`timescale 1ns/1ps

module addr_iter #(
  parameter int ADDR_BITS = sram_bist_pkg::addr_bits_default
) (
  input  wire                  clk,
  input  wire                  reset,
  input  wire logic            inc,
  output sram_bist_pkg::addr_t val,
  output logic                 last
);

  import sram_bist_pkg::*;

  // highest address of the array
  localparam logic [ADDR_BITS-1:0] top_addr = '1;

  logic [ADDR_BITS-1:0] count;

  // wraps to zero naturally on the step after top_addr
  always_ff @(posedge clk) begin
    if (reset) begin
      count <= '0;
    end else if (inc) begin
      count <= count + 1'b1;
    end
  end

  // narrow arrays use the low bits of the address
  assign val  = addr_t'(count);
  assign last = (count == top_addr);

endmodule

`default_nettype wire

//--- common/sram_bist_pkg.sv
`default_nettype none

package sram_bist_pkg;

  // default widths of the external SRAM
  parameter int addr_bits_default = 20;
  parameter int data_bits_default = 16;

  typedef logic [addr_bits_default-1:0] addr_t;
  typedef logic [data_bits_default-1:0] data_t;

  // data patterns, listed in the order the passes run
  typedef enum logic [2:0] {
    pat_zeros,
    pat_ones,
    pat_check,
    pat_icheck,
    pat_addr,
    pat_iaddr
  } pattern_kind_t;

  // sequencer states
  typedef enum logic [2:0] {
    st_start,
    st_writing,
    st_write_hold,
    st_reading,
    st_read_hold,
    st_done,
    st_halt
  } tester_state_t;

  // first miscompare kept for the debugger
  typedef struct packed {
    addr_t addr;
    data_t expected;
    data_t actual;
  } fail_rec_t;

endpackage

`default_nettype wire
